// ==== design/eth_rx_config.svh ====
`ifndef ETH_RX_CONFIG_SVH
`define ETH_RX_CONFIG_SVH

// Framing bytes
`define ETH_PREAMBLE        8'h55
`define ETH_SFD             8'hD5
`define ETH_PREAMBLE_MIN    7               // Preamble bytes needed before SFD

// MAC control pause frame
`define ETH_TYPE_PAUSE      16'h8808
`define ETH_OPC_PAUSE       16'h0001

// Reflected CRC-32, register value after a good frame incl. FCS
`define ETH_CRC_SEED        32'hFFFF_FFFF
`define ETH_CRC_RESIDUE     32'hDEBB_20E3

// Clocks per 512 bit times
`define ETH_QUANTUM_GIG     64
`define ETH_QUANTUM_MII     128             // Byte clock is half rate in 10/100

`endif

// ==== design/eth_rx_pkg.sv ====
package eth_rx_pkg;

    typedef logic [7:0]  byte_t;            // One octet from the PHY
    typedef logic [15:0] quanta_t;          // Pause time in 512 bit-time units

    ////////////////////////////////////////////////////////////
    // State and class encodings
    ////////////////////////////////////////////////////////////

    // Aligner: hunting for preamble, counting it, inside frame
    typedef enum logic [1:0] {
        HUNT,
        PREAMBLE,
        FRAME
    } align_state_e;

    // Output stage vs FIFO ready
    typedef enum logic [1:0] {
        IDLE,
        PASS,                               // Beats going to FIFO
        DISCARD                             // Eat bytes until end of frame
    } out_state_e;

    // Opcode derived frame class
    typedef enum logic {
        FRAME_DATA,
        FRAME_PAUSE
    } frame_kind_e;

endpackage

// ==== design/rx_byte_if.sv ====
`timescale 1ns/10ps

// One framed byte per valid clock, no back-pressure
interface rx_byte_if;
    import eth_rx_pkg::*;

    byte_t data;
    logic  valid;                           // Byte present this clock
    logic  first;                           // First byte after SFD
    logic  last;                            // Final byte of frame
    logic  err;                             // Error so far, sticky to last

    modport source (
        output data, valid, first, last, err
    );

    modport sink (
        input  data, valid, first, last, err
    );

endinterface

// ==== design/rx_sfd_align.sv ====
`timescale 1ns/10ps
`include "eth_rx_config.svh"

module rx_sfd_align (
    input  logic              clk,
    input  logic              reset_n,
    input  eth_rx_pkg::byte_t rx_data,
    input  logic              rx_dv,
    input  logic              rx_er,
    input  logic              rx_en,            // Byte strobe from PHY side
    rx_byte_if.source         out
);
    import eth_rx_pkg::*;

    align_state_e state;
    logic [3:0]   pre_cnt;                      // Consecutive preamble bytes, saturating
    byte_t        hold_data;                    // Byte held one strobe
    logic         hold_vld;
    logic         hold_first;
    logic         err_seen;                     // Sticky rx_er for this frame
    logic         emit;
    logic         emit_last;
    logic         err_next;

    // Held byte leaves on every strobe, last once rx_dv drops
    assign emit      = rx_en && state == FRAME && hold_vld;
    assign emit_last = emit && !rx_dv;
    assign err_next  = err_seen | rx_er;

    ////////////////////////////////////////////////////////////
    // Preamble hunt and frame tracking
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state      <= HUNT;
            pre_cnt    <= 4'd0;
            hold_vld   <= 1'b0;
            hold_first <= 1'b0;
            err_seen   <= 1'b0;
        end else if (rx_en) begin
            case (state)
                HUNT: begin
                    if (rx_dv && rx_data == `ETH_PREAMBLE) begin
                        state   <= PREAMBLE;
                        pre_cnt <= 4'd1;
                    end
                end
                PREAMBLE: begin
                    if (rx_dv && rx_data == `ETH_PREAMBLE) begin
                        if (pre_cnt != 4'hF)
                            pre_cnt <= pre_cnt + 4'd1;
                    end else if (rx_dv && rx_data == `ETH_SFD &&
                                 pre_cnt >= `ETH_PREAMBLE_MIN) begin
                        state      <= FRAME;    // SFD after enough preamble
                        hold_vld   <= 1'b0;
                        hold_first <= 1'b1;
                        err_seen   <= 1'b0;
                    end else begin
                        state   <= HUNT;        // Short preamble or stray byte
                        pre_cnt <= 4'd0;
                    end
                end
                FRAME: begin
                    if (rx_dv) begin
                        hold_vld <= 1'b1;
                        err_seen <= err_next;
                        if (hold_vld)
                            hold_first <= 1'b0; // First one went out now
                    end else begin
                        state    <= HUNT;       // End of frame
                        pre_cnt  <= 4'd0;
                        hold_vld <= 1'b0;
                    end
                end
                default: state <= HUNT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_en && state == FRAME && rx_dv)
            hold_data <= rx_data;
    end

    // Registered stage output
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            out.valid <= 1'b0;
            out.first <= 1'b0;
            out.last  <= 1'b0;
            out.err   <= 1'b0;
        end else begin
            out.valid <= emit;
            out.first <= emit & hold_first;
            out.last  <= emit_last;
            out.err   <= emit & err_next;
        end
    end

    always_ff @(posedge clk) begin
        if (emit)
            out.data <= hold_data;
    end

endmodule

// ==== design/rx_crc_check.sv ====
`timescale 1ns/10ps
`include "eth_rx_config.svh"

module rx_crc_check (
    input  logic      clk,
    input  logic      reset_n,
    rx_byte_if.sink   in,
    rx_byte_if.source out
);
    import eth_rx_pkg::*;

    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;   // Reflected 802.3 polynomial

    // One byte of reflected CRC-32, LSB first
    function automatic logic [31:0] crc_update(input logic [31:0] crc, input byte_t d);
        logic [31:0] c;
        c = crc ^ {24'd0, d};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    logic [31:0] crc_q;
    logic [31:0] crc_next;
    byte_t       fcs_buf [4];               // [3] is the oldest byte
    logic [2:0]  fill;                      // Bytes held, 0 to 4
    logic        first_pend;                // First byte not yet pushed out
    logic        full;
    logic        push;                      // Oldest byte leaves this clock
    logic        crc_bad;

    // Restart from seed on the first byte
    assign crc_next = crc_update(in.first ? `ETH_CRC_SEED : crc_q, in.data);
    assign crc_bad  = crc_next != `ETH_CRC_RESIDUE;
    assign full     = !in.first && fill == 3'd4;
    assign push     = in.valid && full;

    ////////////////////////////////////////////////////////////
    // Holdback fill level
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            fill       <= 3'd0;
            first_pend <= 1'b0;
        end else if (in.valid) begin
            if (in.last) begin
                fill       <= 3'd0;         // Held bytes are the FCS, dropped
                first_pend <= 1'b0;
            end else if (in.first) begin
                fill       <= 3'd1;
                first_pend <= 1'b1;
            end else begin
                if (fill != 3'd4)
                    fill <= fill + 3'd1;
                if (full)
                    first_pend <= 1'b0;
            end
        end
    end

    // CRC register and shift buffer
    always_ff @(posedge clk) begin
        if (in.valid) begin
            crc_q      <= crc_next;
            fcs_buf[0] <= in.data;
            fcs_buf[1] <= fcs_buf[0];
            fcs_buf[2] <= fcs_buf[1];
            fcs_buf[3] <= fcs_buf[2];
        end
    end

    ////////////////////////////////////////////////////////////
    // Output, last moved onto final payload byte
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            out.valid <= 1'b0;
            out.first <= 1'b0;
            out.last  <= 1'b0;
            out.err   <= 1'b0;
        end else begin
            out.valid <= push;
            out.first <= push & first_pend;
            out.last  <= push & in.last;
            out.err   <= push & (in.err | (in.last & crc_bad));   // Residue check at end
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            out.data <= fcs_buf[3];
    end

endmodule

// ==== design/rx_frame_out.sv ====
`timescale 1ns/10ps
`include "eth_rx_config.svh"

module rx_frame_out (
    input  logic                clk,
    input  logic                reset_n,
    rx_byte_if.sink             in,
    input  logic                s_ready,        // FIFO can take a beat
    output eth_rx_pkg::byte_t   m_tdata,
    output logic                m_tvalid,
    output logic                m_tlast,
    output logic                m_tuser,
    output logic                pause_start,
    output eth_rx_pkg::quanta_t pause_quanta
);
    import eth_rx_pkg::*;

    out_state_e  state;
    logic [4:0]  byte_cnt;                      // Header position, saturating
    logic [4:0]  byte_idx;                      // Position of the byte now on in
    logic [15:0] eth_type;
    logic [15:0] opcode;
    quanta_t     quanta;
    frame_kind_e kind;
    logic        bad_end;                       // tuser for a normal last beat

    assign byte_idx     = in.first ? 5'd0 : byte_cnt;
    assign kind         = (eth_type == `ETH_TYPE_PAUSE && opcode == `ETH_OPC_PAUSE) ?
                          FRAME_PAUSE : FRAME_DATA;
    assign bad_end      = in.err | (kind == FRAME_PAUSE);
    assign pause_quanta = quanta;

    // Header fields, big endian on the wire
    always_ff @(posedge clk) begin
        if (in.valid) begin
            if (in.first) begin
                eth_type <= 16'd0;
                opcode   <= 16'd0;
            end
            case (byte_idx)
                5'd12:   eth_type[15:8] <= in.data;
                5'd13:   eth_type[7:0]  <= in.data;
                5'd14:   opcode[15:8]   <= in.data;
                5'd15:   opcode[7:0]    <= in.data;
                5'd16:   quanta[15:8]   <= in.data;
                5'd17:   quanta[7:0]    <= in.data;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // FIFO handshake and drop FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state       <= IDLE;
            byte_cnt    <= 5'd0;
            m_tvalid    <= 1'b0;
            m_tlast     <= 1'b0;
            m_tuser     <= 1'b0;
            pause_start <= 1'b0;
        end else begin
            m_tvalid    <= 1'b0;
            m_tlast     <= 1'b0;
            m_tuser     <= 1'b0;
            pause_start <= in.valid && in.last && !in.err && kind == FRAME_PAUSE;
            if (in.valid) begin
                byte_cnt <= (byte_idx == 5'd31) ? byte_idx : byte_idx + 5'd1;
                case (state)
                    IDLE: begin
                        if (in.first && s_ready) begin
                            m_tvalid <= 1'b1;
                            m_tlast  <= in.last;
                            m_tuser  <= in.last & bad_end;
                            state    <= in.last ? IDLE : PASS;
                        end else if (in.first) begin
                            state <= in.last ? IDLE : DISCARD;  // Not ready at SFD
                        end
                    end
                    PASS: begin
                        m_tvalid <= 1'b1;
                        m_tlast  <= in.last | !s_ready;         // Cut short when ready falls
                        m_tuser  <= (in.last & bad_end) | !s_ready;
                        if (in.last)
                            state <= IDLE;
                        else if (!s_ready)
                            state <= DISCARD;
                    end
                    DISCARD: if (in.last) state <= IDLE;
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid)
            m_tdata <= in.data;
    end

endmodule

// ==== design/rx_pause_timer.sv ====
`timescale 1ns/10ps
`include "eth_rx_config.svh"

module rx_pause_timer (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                mii_sel,        // 10/100 mode, slower quantum
    input  logic                pause_start,
    input  eth_rx_pkg::quanta_t pause_quanta,
    output logic                rx_pause
);
    import eth_rx_pkg::*;

    localparam logic [6:0] LAST_GIG = 7'(`ETH_QUANTUM_GIG - 1);
    localparam logic [6:0] LAST_MII = 7'(`ETH_QUANTUM_MII - 1);

    quanta_t    quanta_left;                    // Remaining quanta
    logic [6:0] clk_cnt;                        // Clocks within current quantum
    logic [6:0] clk_last;

    assign clk_last = mii_sel ? LAST_MII : LAST_GIG;
    assign rx_pause = quanta_left != '0;

    ////////////////////////////////////////////////////////////
    // Quantum counter, reload on a new request
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            quanta_left <= '0;
            clk_cnt     <= 7'd0;
        end else if (pause_start) begin
            quanta_left <= pause_quanta;        // Zero gives no pause
            clk_cnt     <= 7'd0;
        end else if (rx_pause) begin
            if (clk_cnt == clk_last) begin
                clk_cnt     <= 7'd0;
                quanta_left <= quanta_left - 16'd1;
            end else begin
                clk_cnt <= clk_cnt + 7'd1;
            end
        end
    end

endmodule

// ==== design/eth_rx_mac.sv ====
`timescale 1ns/10ps

module eth_rx_mac (
    input  logic              clk,
    input  logic              reset_n,
    input  eth_rx_pkg::byte_t rx_data,
    input  logic              rx_dv,
    input  logic              rx_er,
    input  logic              rx_en,            // Byte strobe
    input  logic              mii_sel,
    input  logic              s_ready,          // FIFO ready
    output eth_rx_pkg::byte_t m_tdata,
    output logic              m_tvalid,
    output logic              m_tlast,
    output logic              m_tuser,
    output logic              rx_pause
);
    import eth_rx_pkg::*;

    logic    pause_start;
    quanta_t pause_quanta;

    rx_byte_if a2c ();                          // Aligner to CRC check
    rx_byte_if c2f ();                          // CRC check to frame stage

    ////////////////////////////////////////////////////////////
    // Receive pipeline
    ////////////////////////////////////////////////////////////
    rx_sfd_align u_align (
        .clk     (clk),
        .reset_n (reset_n),
        .rx_data (rx_data),
        .rx_dv   (rx_dv),
        .rx_er   (rx_er),
        .rx_en   (rx_en),
        .out     (a2c.source)
    );

    rx_crc_check u_crc (
        .clk     (clk),
        .reset_n (reset_n),
        .in      (a2c.sink),
        .out     (c2f.source)
    );

    rx_frame_out u_frame (
        .clk          (clk),
        .reset_n      (reset_n),
        .in           (c2f.sink),
        .s_ready      (s_ready),
        .m_tdata      (m_tdata),
        .m_tvalid     (m_tvalid),
        .m_tlast      (m_tlast),
        .m_tuser      (m_tuser),
        .pause_start  (pause_start),
        .pause_quanta (pause_quanta)
    );

    rx_pause_timer u_pause (
        .clk          (clk),
        .reset_n      (reset_n),
        .mii_sel      (mii_sel),
        .pause_start  (pause_start),
        .pause_quanta (pause_quanta),
        .rx_pause     (rx_pause)
    );

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic reset_n
);
    initial clk = 1'b0;
    always #50 clk = ~clk;                  // 100 ns period

    // Reset low for 8 clocks, released on a falling edge
    initial begin
        reset_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

// ==== tb/eth_rx_tb.sv ====
`timescale 1ns/10ps
`include "eth_rx_config.svh"

module eth_rx_tb;
    import eth_rx_pkg::*;

    localparam int unsigned RAND_SEED = 32'h7bf4_8e59;
    localparam int BODY_LEN    = 60;                        // 64 byte frame less FCS
    localparam int IFG_LEN     = 12;                        // Idle strobes after a frame
    localparam int FRAME_BYTES = 8 + BODY_LEN + 4 + IFG_LEN;
    localparam int NUM_FRAMES  = 12;
    localparam int SLOW_CLKS   = 4;                         // Worst case clocks per byte
    localparam int PAUSE_CLKS  = 3 * `ETH_QUANTUM_GIG + 3 * `ETH_QUANTUM_MII;
    localparam int TIMEOUT_CLKS = 2 * (NUM_FRAMES * FRAME_BYTES * SLOW_CLKS + PAUSE_CLKS);

    logic  clk;
    logic  reset_n;
    byte_t rx_data;
    logic  rx_dv;
    logic  rx_er;
    logic  rx_en;
    logic  mii_sel;
    logic  s_ready;
    byte_t m_tdata;
    logic  m_tvalid;
    logic  m_tlast;
    logic  m_tuser;
    logic  rx_pause;

    byte_t       beat_q [$];                // Collected stream beats
    logic        last_q [$];
    logic        user_q [$];
    logic        last_seen = 1'b0;
    frame_kind_e last_kind = FRAME_DATA;    // Class seen at the last beat
    int          pause_clks = 0;
    int          cycles = 0;
    int          value_errs = 0;
    int          other_errs = 0;
    int unsigned seed_draw;

    tb_clk_gen u_clk_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    eth_rx_mac u_dut (
        .clk      (clk),
        .reset_n  (reset_n),
        .rx_data  (rx_data),
        .rx_dv    (rx_dv),
        .rx_er    (rx_er),
        .rx_en    (rx_en),
        .mii_sel  (mii_sel),
        .s_ready  (s_ready),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser),
        .rx_pause (rx_pause)
    );

    ////////////////////////////////////////////////////////////
    // Monitor and watchdog
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rx_pause)
            pause_clks++;                   // Clocks with pause asserted
        if (m_tvalid) begin
            beat_q.push_back(m_tdata);
            last_q.push_back(m_tlast);
            user_q.push_back(m_tuser);
            if (m_tlast) begin
                last_seen = 1'b1;
                last_kind = u_dut.u_frame.kind;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CLKS) begin
            $display("Error: run stopped at the cycle limit of %0d", TIMEOUT_CLKS);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic compare_byte(input string name, input byte_t exp, input byte_t act);
        if (exp !== act) begin
            value_errs++;
            $display("[FAIL] %s: expected 8'h%02h, actual 8'h%02h", name, exp, act);
        end
    endtask

    task automatic compare_kind(input string name, input frame_kind_e exp,
                                input frame_kind_e act);
        if (exp !== act) begin
            value_errs++;
            $display("[FAIL] %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic compare_clocks(input string name, input int exp, input int act);
        if (exp != act) begin
            value_errs++;
            $display("[FAIL] %s: expected %0d pause clocks, actual %0d", name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Frame building and reference CRC
    ////////////////////////////////////////////////////////////
    // Bit serial 802.3 CRC with LSB first
    function automatic logic [31:0] ref_crc(input byte_t q[$]);
        logic [31:0] c;
        logic        fb;
        c = `ETH_CRC_SEED;
        foreach (q[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ q[i][b];
                c  = c >> 1;
                if (fb)
                    c = c ^ 32'hEDB8_8320;
            end
        end
        return c;
    endfunction

    function automatic frame_kind_e expect_kind(input byte_t body[$]);
        if ({body[12], body[13]} == `ETH_TYPE_PAUSE && {body[14], body[15]} == `ETH_OPC_PAUSE)
            return FRAME_PAUSE;
        return FRAME_DATA;
    endfunction

    // Addresses and payload random with fixed header fields
    task automatic make_body(input logic [15:0] eth_type, input logic [15:0] opcode,
                             input quanta_t quanta, output byte_t body[$]);
        body = {};
        for (int i = 0; i < BODY_LEN; i++)
            body.push_back(byte_t'($urandom_range(0, 255)));
        body[12] = eth_type[15:8];
        body[13] = eth_type[7:0];
        body[14] = opcode[15:8];
        body[15] = opcode[7:0];
        body[16] = quanta[15:8];
        body[17] = quanta[7:0];
    endtask

    task automatic build_frame(input byte_t body[$], input int pre_len, output byte_t octets[$]);
        logic [31:0] fcs;
        octets = {};
        repeat (pre_len) octets.push_back(`ETH_PREAMBLE);
        octets.push_back(`ETH_SFD);
        foreach (body[i]) octets.push_back(body[i]);
        fcs = ~ref_crc(body);               // Sent inverted and low byte first
        octets.push_back(fcs[7:0]);
        octets.push_back(fcs[15:8]);
        octets.push_back(fcs[23:16]);
        octets.push_back(fcs[31:24]);
    endtask

    ////////////////////////////////////////////////////////////
    // PHY side drive
    ////////////////////////////////////////////////////////////
    task automatic send_byte(input byte_t d, input logic dv, input logic er, input bit gaps);
        int n;
        if (gaps) begin
            n = $urandom_range(1, 3);       // 10/100 strobe spacing
            repeat (n) begin
                @(negedge clk);
                rx_en = 1'b0;
            end
        end
        @(negedge clk);
        rx_data = d;
        rx_dv   = dv;
        rx_er   = er;
        rx_en   = 1'b1;
    endtask

    // er_at pulses rx_er and drop_at pulls s_ready low until the gap ends
    task automatic drive_frame(input byte_t octets[$], input int er_at, input int drop_at,
                               input bit gaps);
        foreach (octets[i]) begin
            send_byte(octets[i], 1'b1, i == er_at, gaps);
            if (i == drop_at)
                s_ready = 1'b0;
        end
        repeat (IFG_LEN) send_byte(8'h00, 1'b0, 1'b0, gaps);
        s_ready = 1'b1;
    endtask

    task automatic clear_beats();
        beat_q.delete();
        last_q.delete();
        user_q.delete();
        last_seen = 1'b0;
    endtask

    task automatic wait_frame_end(input string name);
        int n;
        n = 0;
        while (!last_seen && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (!last_seen) begin
            other_errs++;
            $display("Error: %s: no beat with tlast came out", name);
        end
    endtask

    task automatic wait_pause_end();
        while (rx_pause)
            @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // Response checks
    ////////////////////////////////////////////////////////////
    // whole = 0 means the frame was cut by back-pressure
    task automatic check_beats(input string name, input byte_t exp[$], input logic exp_user,
                               input bit whole);
        int n;
        n = beat_q.size();
        if (whole && n != exp.size()) begin
            other_errs++;
            $display("Error: %s: got %0d beats where %0d were due", name, n, exp.size());
        end
        if (!whole && (n == 0 || n >= exp.size())) begin
            other_errs++;
            $display("Error: %s: frame was not cut short, %0d beats", name, n);
        end
        for (int i = 0; i < n && i < exp.size(); i++) begin
            compare_byte($sformatf("%s beat %0d", name, i), exp[i], beat_q[i]);
            if (last_q[i] !== (i == n - 1)) begin
                other_errs++;
                $display("Error: %s: tlast wrong on beat %0d", name, i);
            end
            if (user_q[i] !== ((i == n - 1) ? exp_user : 1'b0)) begin
                other_errs++;
                $display("Error: %s: tuser wrong on beat %0d", name, i);
            end
        end
    endtask

    task automatic check_no_beats(input string name);
        if (beat_q.size() != 0) begin
            other_errs++;
            $display("Error: %s: %0d beats came out of a dropped frame", name, beat_q.size());
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic good_frame();
        byte_t body[$];
        byte_t octets[$];
        if (m_tvalid !== 1'b0 || m_tlast !== 1'b0 || m_tuser !== 1'b0 || rx_pause !== 1'b0) begin
            other_errs++;
            $display("Error: outputs not all low after reset");
        end
        make_body(16'h0800, 16'h4500, 16'd0, body);
        build_frame(body, 7, octets);
        clear_beats();
        drive_frame(octets, -1, -1, 1'b0);
        wait_frame_end("good frame");
        check_beats("good frame", body, 1'b0, 1'b1);
        compare_kind("good frame", expect_kind(body), last_kind);
    endtask

    task automatic corrupted_frames();
        byte_t body[$];
        byte_t octets[$];
        make_body(16'h0800, 16'h4500, 16'd0, body);
        build_frame(body, 7, octets);
        octets[octets.size() - 2] ^= 8'h10; // One FCS bit flipped
        clear_beats();
        drive_frame(octets, -1, -1, 1'b0);
        wait_frame_end("bad fcs");
        check_beats("bad fcs", body, 1'b1, 1'b1);
        make_body(16'h86DD, 16'h6000, 16'd0, body);
        build_frame(body, 7, octets);
        clear_beats();
        drive_frame(octets, 8 + 20, -1, 1'b0);  // rx_er inside the payload
        wait_frame_end("rx_er frame");
        check_beats("rx_er frame", body, 1'b1, 1'b1);
    endtask

    task automatic preamble_rules();
        byte_t body[$];
        byte_t octets[$];
        make_body(16'h0800, 16'h4500, 16'd0, body);
        build_frame(body, 6, octets);       // One preamble byte short
        clear_beats();
        drive_frame(octets, -1, -1, 1'b0);
        check_no_beats("short preamble");
        build_frame(body, 8, octets);
        octets[6] = 8'h54;                  // Broken preamble before SFD
        clear_beats();
        drive_frame(octets, -1, -1, 1'b0);
        check_no_beats("broken preamble");
        build_frame(body, 7, octets);
        clear_beats();
        drive_frame(octets, -1, -1, 1'b0);
        wait_frame_end("after preamble errors");
        check_beats("after preamble errors", body, 1'b0, 1'b1);
    endtask

    task automatic pause_frames();
        byte_t body[$];
        byte_t octets[$];
        make_body(`ETH_TYPE_PAUSE, `ETH_OPC_PAUSE, 16'd3, body);
        build_frame(body, 7, octets);
        clear_beats();
        pause_clks = 0;
        drive_frame(octets, -1, -1, 1'b0);
        wait_frame_end("pause gig");
        check_beats("pause gig", body, 1'b1, 1'b1);
        compare_kind("pause gig", FRAME_PAUSE, last_kind);
        wait_pause_end();
        compare_clocks("pause gig", 3 * `ETH_QUANTUM_GIG, pause_clks);

        mii_sel = 1'b1;                     // 10/100 with strobe gaps
        make_body(`ETH_TYPE_PAUSE, `ETH_OPC_PAUSE, 16'd3, body);
        build_frame(body, 7, octets);
        clear_beats();
        pause_clks = 0;
        drive_frame(octets, -1, -1, 1'b1);
        wait_frame_end("pause mii");
        check_beats("pause mii", body, 1'b1, 1'b1);
        compare_kind("pause mii", FRAME_PAUSE, last_kind);
        wait_pause_end();
        compare_clocks("pause mii", 3 * `ETH_QUANTUM_MII, pause_clks);
        mii_sel = 1'b0;

        make_body(`ETH_TYPE_PAUSE, `ETH_OPC_PAUSE, 16'd3, body);
        build_frame(body, 7, octets);
        octets[octets.size() - 1] ^= 8'h01;
        clear_beats();
        pause_clks = 0;
        drive_frame(octets, -1, -1, 1'b0);
        wait_frame_end("pause bad fcs");
        check_beats("pause bad fcs", body, 1'b1, 1'b1);
        compare_clocks("pause bad fcs", 0, pause_clks);
    endtask

    task automatic back_pressure();
        byte_t body[$];
        byte_t octets[$];
        make_body(16'h0800, 16'h4500, 16'd0, body);
        build_frame(body, 7, octets);
        clear_beats();
        drive_frame(octets, -1, 0, 1'b0);   // Not ready before the SFD
        check_no_beats("not ready at sfd");
        clear_beats();
        drive_frame(octets, -1, 8 + 30, 1'b0);  // Ready lost mid frame
        wait_frame_end("ready lost");
        check_beats("ready lost", body, 1'b1, 1'b0);
        make_body(16'h0806, 16'h0001, 16'd0, body);
        build_frame(body, 7, octets);
        clear_beats();
        drive_frame(octets, -1, -1, 1'b0);
        wait_frame_end("after drop");
        check_beats("after drop", body, 1'b0, 1'b1);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        rx_data   = 8'h00;
        rx_dv     = 1'b0;
        rx_er     = 1'b0;
        rx_en     = 1'b0;
        mii_sel   = 1'b0;
        s_ready   = 1'b1;
        seed_draw = $urandom(RAND_SEED);
        wait (reset_n === 1'b1);
        @(negedge clk);
        rx_en = 1'b1;                       // Gigabit idle has a strobe every clock
        good_frame();
        corrupted_frames();
        preamble_rules();
        pause_frames();
        back_pressure();
        $display("Summary: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+design
design/eth_rx_pkg.sv
design/rx_byte_if.sv
design/rx_sfd_align.sv
design/rx_crc_check.sv
design/rx_frame_out.sv
design/rx_pause_timer.sv
design/eth_rx_mac.sv
tb/tb_clk_gen.sv
tb/eth_rx_tb.sv
